// File: Makefile
# Verilator build and run for the radix-4 butterfly testbench

VERILATOR ?= verilator
TOP       ?= tb_radix4_butterfly
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/fft_r4_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	   echo "simulation result in $(LOG): pass"; \
	else \
	   echo "simulation result in $(LOG): fail"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+common
common/fft_r4_pkg.sv
common/r4_quad_if.sv
src/fft_r4_ctrl.sv
butterfly/r4_adder_tree.sv
twiddle/twiddle_rom.sv
twiddle/r4_twiddle_stage.sv
src/radix4_butterfly.sv
verification/tb_clkgen.sv
verification/tb_checker.sv
verification/tb_radix4_butterfly.sv

// File: butterfly/r4_adder_tree.sv
`timescale 1ns/1ps

module r4_adder_tree import fft_r4_pkg::*; (
   input  logic         clk,
   input  cplx_t        a0,
   input  cplx_t        a1,
   input  cplx_t        a2,
   input  cplx_t        a3,
   r4_quad_if.src       c
);

   cplx_t b0;
   cplx_t b1;
   cplx_t b2;
   cplx_t b3;

   // All sums wrap in 11 bits
   function automatic cplx_t cadd(input cplx_t x, input cplx_t y);
      cplx_t r;
      r.re = x.re + y.re;
      r.im = x.im + y.im;
      return r;
   endfunction

   function automatic cplx_t csub(input cplx_t x, input cplx_t y);
      cplx_t r;
      r.re = x.re - y.re;
      r.im = x.im - y.im;
      return r;
   endfunction

   // j * (re + j im) = -im + j re
   function automatic cplx_t mul_j(input cplx_t x);
      cplx_t r;
      r.re = -x.im;
      r.im = x.re;
      return r;
   endfunction

   // Rank 1
   always_ff @(posedge clk) begin
      b0 <= cadd(a0, a2);
      b1 <= cadd(a1, a3);
      b2 <= csub(a0, a2);
      b3 <= csub(a1, a3);
   end

   // Rank 2 with the j rotation kept combinational
   always_ff @(posedge clk) begin
      c.x0 <= cadd(b0, b1);
      c.x1 <= csub(b2, mul_j(b3));   // a0 - j a1 - a2 + j a3
      c.x2 <= csub(b0, b1);
      c.x3 <= cadd(b2, mul_j(b3));   // a0 + j a1 - a2 - j a3
   end

endmodule

// File: common/fft_r4_pkg.sv
`include "fft_r4_settings.svh"

package fft_r4_pkg;

   // One part of a complex sample
   typedef logic signed [`FFT_R4_SAMPLE_W-1:0] sample_t;

   // Real part sits in the upper bits
   typedef struct packed {
      sample_t re;
      sample_t im;
   } cplx_t;

   typedef logic signed [`FFT_R4_TW_W-1:0] tw_t;

   // Stored as cos and -sin
   typedef struct packed {
      tw_t re;
      tw_t im;
   } twiddle_t;

   typedef logic [`FFT_R4_IDX_W-1:0] tw_idx_t;

endpackage

// File: common/fft_r4_settings.svh
`ifndef FFT_R4_SETTINGS_SVH
`define FFT_R4_SETTINGS_SVH

// Real or imaginary part of a sample
`define FFT_R4_SAMPLE_W 11

// Twiddle part with unity at 65535
`define FFT_R4_TW_W 17

// Fraction bits dropped after the twiddle multiply
`define FFT_R4_TW_FRAC 16

`define FFT_R4_N 64
`define FFT_R4_IDX_W 6

// Input strobe to output strobe
`define FFT_R4_LATENCY 3

`endif

// File: common/r4_quad_if.sv
`timescale 1ns/1ps

// Four complex values moving between pipeline stages
interface r4_quad_if import fft_r4_pkg::*; ();

   cplx_t x0;
   cplx_t x1;
   cplx_t x2;
   cplx_t x3;

   modport src (
      output x0, x1, x2, x3
   );

   modport dst (
      input x0, x1, x2, x3
   );

endinterface

// File: src/fft_r4_ctrl.sv
`timescale 1ns/1ps
`include "fft_r4_settings.svh"

module fft_r4_ctrl import fft_r4_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    valid_i,
   input  tw_idx_t k,
   output tw_idx_t k_q,
   output logic    valid_o
);

   // One bit per pipeline stage
   logic [`FFT_R4_LATENCY-1:0] valid_sr;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[`FFT_R4_LATENCY-2:0], valid_i};
      end
   end

   assign valid_o = valid_sr[`FFT_R4_LATENCY-1];

   // Index moves with the first adder rank
   always_ff @(posedge clk) begin
      k_q <= k;
   end

endmodule

// File: src/radix4_butterfly.sv
`timescale 1ns/1ps

module radix4_butterfly import fft_r4_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid_i,
   input  tw_idx_t                  k,
   input  logic [$bits(cplx_t)-1:0] a0,
   input  logic [$bits(cplx_t)-1:0] a1,
   input  logic [$bits(cplx_t)-1:0] a2,
   input  logic [$bits(cplx_t)-1:0] a3,
   output logic [$bits(cplx_t)-1:0] y0,
   output logic [$bits(cplx_t)-1:0] y1,
   output logic [$bits(cplx_t)-1:0] y2,
   output logic [$bits(cplx_t)-1:0] y3,
   output logic                     valid_o
);

   tw_idx_t  k_q;
   twiddle_t w1;
   twiddle_t w2;
   twiddle_t w3;

   r4_quad_if quad_c ();   // Adder tree result
   r4_quad_if quad_y ();   // Rotated result

   fft_r4_ctrl u_fft_r4_ctrl (
      .clk     (clk),
      .rst     (rst),
      .valid_i (valid_i),
      .k       (k),
      .k_q     (k_q),
      .valid_o (valid_o)
   );

   r4_adder_tree u_r4_adder_tree (
      .clk (clk),
      .a0  (a0),
      .a1  (a1),
      .a2  (a2),
      .a3  (a3),
      .c   (quad_c.src)
   );

   twiddle_rom u_twiddle_rom (
      .clk (clk),
      .k_q (k_q),
      .w1  (w1),
      .w2  (w2),
      .w3  (w3)
   );

   r4_twiddle_stage u_r4_twiddle_stage (
      .clk (clk),
      .c   (quad_c.dst),
      .w1  (w1),
      .w2  (w2),
      .w3  (w3),
      .y   (quad_y.src)
   );

   assign y0 = quad_y.x0;
   assign y1 = quad_y.x1;
   assign y2 = quad_y.x2;
   assign y3 = quad_y.x3;

endmodule

// File: twiddle/r4_twiddle_stage.sv
`timescale 1ns/1ps
`include "fft_r4_settings.svh"

module r4_twiddle_stage import fft_r4_pkg::*; (
   input  logic     clk,
   r4_quad_if.dst   c,
   input  twiddle_t w1,
   input  twiddle_t w2,
   input  twiddle_t w3,
   r4_quad_if.src   y
);

   // Full complex product plus one guard bit for the add
   localparam int prod_w = `FFT_R4_SAMPLE_W + `FFT_R4_TW_W + 1;
   localparam int keep_lsb = `FFT_R4_TW_FRAC;
   localparam int keep_msb = `FFT_R4_TW_FRAC + `FFT_R4_SAMPLE_W - 1;

   cplx_t x1_rot;
   cplx_t x2_rot;
   cplx_t x3_rot;

   // Arithmetic shift by 16, then keep the low 11 bits
   function automatic cplx_t rotate(input cplx_t x, input twiddle_t w);
      logic signed [prod_w-1:0] x_re;
      logic signed [prod_w-1:0] x_im;
      logic signed [prod_w-1:0] w_re;
      logic signed [prod_w-1:0] w_im;
      logic signed [prod_w-1:0] p_re;
      logic signed [prod_w-1:0] p_im;
      cplx_t r;
      x_re = prod_w'(x.re);
      x_im = prod_w'(x.im);
      w_re = prod_w'(w.re);
      w_im = prod_w'(w.im);
      p_re = x_re * w_re - x_im * w_im;
      p_im = x_re * w_im + x_im * w_re;
      r.re = p_re[keep_msb:keep_lsb];
      r.im = p_im[keep_msb:keep_lsb];
      return r;
   endfunction

   assign x1_rot = rotate(c.x1, w1);
   assign x2_rot = rotate(c.x2, w2);
   assign x3_rot = rotate(c.x3, w3);

   always_ff @(posedge clk) begin
      y.x0 <= c.x0;   // Unrotated and delayed to line up
      y.x1 <= x1_rot;
      y.x2 <= x2_rot;
      y.x3 <= x3_rot;
   end

endmodule

// File: twiddle/twiddle_rom.sv
`timescale 1ns/1ps
`include "fft_r4_settings.svh"

module twiddle_rom import fft_r4_pkg::*; (
   input  logic     clk,
   input  tw_idx_t  k_q,
   output twiddle_t w1,
   output twiddle_t w2,
   output twiddle_t w3
);

   localparam int quarter = `FFT_R4_N / 4;

   // round(65535 * cos(2 pi i / 64)) over one quarter wave
   localparam tw_t qw_table [0:quarter] = '{
      17'sd65535, 17'sd65219, 17'sd64276, 17'sd62713,
      17'sd60546, 17'sd57797, 17'sd54490, 17'sd50659,
      17'sd46340, 17'sd41575, 17'sd36409, 17'sd30893,
      17'sd25079, 17'sd19024, 17'sd12785, 17'sd6424,
      17'sd0
   };

   tw_idx_t idx2;
   tw_idx_t idx3;

   // Both wrap mod 64
   assign idx2 = k_q << 1;
   assign idx3 = k_q + idx2;

   function automatic twiddle_t lookup(input tw_idx_t n);
      logic [`FFT_R4_IDX_W-3:0] r;
      tw_t near;
      tw_t far;
      twiddle_t w;
      r = n[`FFT_R4_IDX_W-3:0];
      near = qw_table[int'(r)];          // cos of offset in quadrant
      far = qw_table[quarter - int'(r)]; // sin of offset in quadrant
      case (n[`FFT_R4_IDX_W-1 -: 2])
         2'd0: begin
            w.re = near;
            w.im = -far;
         end
         2'd1: begin
            w.re = -far;
            w.im = -near;
         end
         2'd2: begin
            w.re = -near;
            w.im = far;
         end
         default: begin
            w.re = far;
            w.im = near;
         end
      endcase
      return w;
   endfunction

   always_ff @(posedge clk) begin
      w1 <= lookup(k_q);
      w2 <= lookup(idx2);
      w3 <= lookup(idx3);
   end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps
`include "fft_r4_settings.svh"

module tb_checker #(
   parameter int cw = 2 * `FFT_R4_SAMPLE_W
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid_i,
   input  logic [`FFT_R4_IDX_W-1:0] k,
   input  logic [cw-1:0]            exp_y0,
   input  logic [cw-1:0]            exp_y1,
   input  logic [cw-1:0]            exp_y2,
   input  logic [cw-1:0]            exp_y3,
   input  logic [cw-1:0]            y0,
   input  logic [cw-1:0]            y1,
   input  logic [cw-1:0]            y2,
   input  logic [cw-1:0]            y3,
   input  logic                     valid_o,
   output int                       pending,
   output int                       checks,
   output int                       errors
);

   logic [4*cw-1:0]          exp_q [$];   // y0 in the top bits
   logic [`FFT_R4_IDX_W-1:0] k_q [$];
   int                       stamp_q [$];  // Cycle of entry
   int                       cycle;
   int                       test_no;

   always @(posedge clk) begin
      logic [4*cw-1:0]          want;
      logic [4*cw-1:0]          got;
      logic [`FFT_R4_IDX_W-1:0] item_k;
      int                       stamp;
      bit                       bad;
      if (!rst) begin
         exp_q.delete();
         k_q.delete();
         stamp_q.delete();
         cycle = 0;
         test_no = 0;
         pending = 0;
         checks = 0;
         errors = 0;
      end else begin
         cycle = cycle + 1;
         if (valid_o) begin
            if (exp_q.size() == 0) begin
               errors = errors + 1;
               $display("error at %0d ns: output strobe with no item pending", $time);
            end else begin
               want = exp_q.pop_front();
               item_k = k_q.pop_front();
               stamp = stamp_q.pop_front();
               got = {y0, y1, y2, y3};
               bad = 1'b0;
               test_no = test_no + 1;
               if (cycle - stamp != `FFT_R4_LATENCY) begin
                  bad = 1'b1;
                  $display("error at %0d ns: test %0d came after %0d cycles, expected %0d",
                           $time, test_no, cycle - stamp, `FFT_R4_LATENCY);
               end
               for (int i = 0; i < 4; i++) begin
                  if (got[(3-i)*cw +: cw] !== want[(3-i)*cw +: cw]) begin
                     bad = 1'b1;
                     $display("error at %0d ns: test %0d y%0d is %h, expected %h",
                              $time, test_no, i, got[(3-i)*cw +: cw], want[(3-i)*cw +: cw]);
                  end
               end
               checks = checks + 1;
               if (bad) begin
                  errors = errors + 1;
               end
               $display("test %0d k=%0d %s", test_no, item_k, bad ? "failed" : "ok");
            end
         end
         if (valid_i) begin
            exp_q.push_back({exp_y0, exp_y1, exp_y2, exp_y3});
            k_q.push_back(k);
            stamp_q.push_back(cycle);
         end
         pending = exp_q.size();
      end
   end

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // Released on a falling edge away from the sampling edge
   initial begin
      rst = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
   end

endmodule

// File: verification/tb_radix4_butterfly.sv
`timescale 1ns/1ps
`include "fft_r4_settings.svh"

module tb_radix4_butterfly;

   localparam int sw = `FFT_R4_SAMPLE_W;
   localparam int cw = 2 * sw;
   localparam int n_rows = 34;
   localparam int n_groups = 5;
   localparam int timeout_cycles = 40;
   // Single item, k = 0 DFT, quadrants, full scale, random burst
   localparam int grp_count [0:n_groups-1] = '{1, 3, 6, 4, 20};

   logic                     clk;
   logic                     rst;
   logic                     valid_i;
   logic                     valid_o;
   logic [`FFT_R4_IDX_W-1:0] k;
   logic [cw-1:0]            a0, a1, a2, a3;
   logic [cw-1:0]            y0, y1, y2, y3;
   logic [cw-1:0]            exp_y0, exp_y1, exp_y2, exp_y3;
   int                       pending;
   int                       checks;
   int                       errors;

   logic [cw-1:0]            tab_a [0:n_rows-1][0:3];
   logic [`FFT_R4_IDX_W-1:0] tab_k [0:n_rows-1];
   logic [cw-1:0]            tab_y [0:n_rows-1][0:3];
   int                       n_filled;
   int                       tw_re [0:`FFT_R4_N-1];
   int                       tw_im [0:`FFT_R4_N-1];
   int unsigned              lcg_state;
   bit                       timed_out;

   tb_clkgen #(.period_ns(100), .reset_cycles(3)) u_clkgen (.clk(clk), .rst(rst));

   radix4_butterfly u_radix4_butterfly (
      .clk     (clk),
      .rst     (rst),
      .valid_i (valid_i),
      .k       (k),
      .a0      (a0),
      .a1      (a1),
      .a2      (a2),
      .a3      (a3),
      .y0      (y0),
      .y1      (y1),
      .y2      (y2),
      .y3      (y3),
      .valid_o (valid_o)
   );

   tb_checker #(.cw(cw)) u_checker (
      .clk     (clk),
      .rst     (rst),
      .valid_i (valid_i),
      .k       (k),
      .exp_y0  (exp_y0),
      .exp_y1  (exp_y1),
      .exp_y2  (exp_y2),
      .exp_y3  (exp_y3),
      .y0      (y0),
      .y1      (y1),
      .y2      (y2),
      .y3      (y3),
      .valid_o (valid_o),
      .pending (pending),
      .checks  (checks),
      .errors  (errors)
   );

   function automatic logic [cw-1:0] make_cplx(input int re, input int im);
      return {re[sw-1:0], im[sw-1:0]};
   endfunction

   function automatic int to_int(input logic [sw-1:0] v);
      return int'($signed(v));
   endfunction

   function automatic int wrap_part(input int v);
      return to_int(v[sw-1:0]);
   endfunction

   // Arithmetic shift, then the low bits of the part
   function automatic int scale_product(input longint p);
      longint s;
      s = p >>> `FFT_R4_TW_FRAC;
      return to_int(s[sw-1:0]);
   endfunction

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic int rand_part();
      int unsigned v;
      v = lcg_next();
      return int'(v[26:16]) - 1024;
   endfunction

   function automatic logic [cw-1:0] rand_cplx();
      int re;
      int im;
      re = rand_part();
      im = rand_part();
      return make_cplx(re, im);
   endfunction

   function automatic int rand_index();
      int unsigned v;
      v = lcg_next();
      return int'(v[21:16]);
   endfunction

   // Halves round away from zero
   function automatic int round_to_int(input real v);
      if (v < 0.0) begin
         return -$rtoi(0.5 - v);
      end
      return $rtoi(v + 0.5);
   endfunction

   // W^n = cos - j sin with parts rounded to the nearest integer
   task automatic build_twiddles();
      real ang;
      for (int n = 0; n < `FFT_R4_N; n++) begin
         ang = 2.0 * 3.14159265358979 * n / `FFT_R4_N;
         tw_re[n] = round_to_int(65535.0 * $cos(ang));
         tw_im[n] = round_to_int(-65535.0 * $sin(ang));
      end
   endtask

   task automatic model_row(input int r);
      int     are [4];
      int     aim [4];
      int     b_re [4];
      int     b_im [4];
      int     x_re [4];
      int     x_im [4];
      int     jr;
      int     ji;
      int     idx;
      longint p_re;
      longint p_im;
      for (int i = 0; i < 4; i++) begin
         are[i] = to_int(tab_a[r][i][cw-1:sw]);
         aim[i] = to_int(tab_a[r][i][sw-1:0]);
      end
      for (int i = 0; i < 2; i++) begin
         b_re[i] = wrap_part(are[i] + are[i+2]);
         b_im[i] = wrap_part(aim[i] + aim[i+2]);
         b_re[i+2] = wrap_part(are[i] - are[i+2]);
         b_im[i+2] = wrap_part(aim[i] - aim[i+2]);
      end
      jr = wrap_part(-b_im[3]);   // j * b3
      ji = b_re[3];
      x_re[0] = wrap_part(b_re[0] + b_re[1]);
      x_im[0] = wrap_part(b_im[0] + b_im[1]);
      x_re[1] = wrap_part(b_re[2] - jr);
      x_im[1] = wrap_part(b_im[2] - ji);
      x_re[2] = wrap_part(b_re[0] - b_re[1]);
      x_im[2] = wrap_part(b_im[0] - b_im[1]);
      x_re[3] = wrap_part(b_re[2] + jr);
      x_im[3] = wrap_part(b_im[2] + ji);
      tab_y[r][0] = make_cplx(x_re[0], x_im[0]);
      for (int i = 1; i < 4; i++) begin
         idx = (i * int'(tab_k[r])) % `FFT_R4_N;
         p_re = longint'(x_re[i]) * longint'(tw_re[idx])
              - longint'(x_im[i]) * longint'(tw_im[idx]);
         p_im = longint'(x_re[i]) * longint'(tw_im[idx])
              + longint'(x_im[i]) * longint'(tw_re[idx]);
         tab_y[r][i] = make_cplx(scale_product(p_re), scale_product(p_im));
      end
   endtask

   task automatic add_row(input logic [cw-1:0] x0, input logic [cw-1:0] x1,
                          input logic [cw-1:0] x2, input logic [cw-1:0] x3, input int kk);
      tab_a[n_filled][0] = x0;
      tab_a[n_filled][1] = x1;
      tab_a[n_filled][2] = x2;
      tab_a[n_filled][3] = x3;
      tab_k[n_filled] = kk[`FFT_R4_IDX_W-1:0];
      model_row(n_filled);
      n_filled = n_filled + 1;
   endtask

   task automatic build_table();
      int ks [6];
      ks = '{0, 8, 16, 24, 48, 63};
      add_row(make_cplx(100, -50), make_cplx(20, 30), make_cplx(-7, 0), make_cplx(1, 1), 0);
      // Plain 4-point DFT
      add_row(make_cplx(200, 0), make_cplx(0, 0), make_cplx(0, 0), make_cplx(0, 0), 0);
      add_row(make_cplx(300, 0), make_cplx(0, 300), make_cplx(-300, 0), make_cplx(0, -300), 0);
      add_row(make_cplx(10, 20), make_cplx(30, -40), make_cplx(-50, 60), make_cplx(70, 80), 0);
      for (int i = 0; i < 6; i++) begin
         add_row(rand_cplx(), rand_cplx(), rand_cplx(), rand_cplx(), ks[i]);
      end
      // Near full scale so the sums wrap
      add_row(make_cplx(1023, 1023), make_cplx(1023, 1023),
              make_cplx(1023, 1023), make_cplx(1023, 1023), 0);
      add_row(make_cplx(-1024, -1024), make_cplx(-1024, -1024),
              make_cplx(-1024, -1024), make_cplx(-1024, -1024), 5);
      add_row(make_cplx(1023, -1024), make_cplx(-1024, 1023),
              make_cplx(1023, 1023), make_cplx(-1024, -1024), 40);
      add_row(make_cplx(1023, 0), make_cplx(0, 1023), make_cplx(-1023, 0), make_cplx(0, -1023), 63);
      for (int i = 0; i < 20; i++) begin
         add_row(rand_cplx(), rand_cplx(), rand_cplx(), rand_cplx(), rand_index());
      end
   endtask

   task automatic drive_rows(input int first, input int count);
      for (int r = first; r < first + count; r++) begin
         @(negedge clk);
         valid_i = 1'b1;
         k = tab_k[r];
         a0 = tab_a[r][0];
         a1 = tab_a[r][1];
         a2 = tab_a[r][2];
         a3 = tab_a[r][3];
         exp_y0 = tab_y[r][0];
         exp_y1 = tab_y[r][1];
         exp_y2 = tab_y[r][2];
         exp_y3 = tab_y[r][3];
      end
      @(negedge clk);
      valid_i = 1'b0;
   endtask

   task automatic wait_reset(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < timeout_cycles && !ok; n++) begin
         @(posedge clk);
         ok = rst;
      end
      if (!ok) begin
         $display("reset was never released");
      end
   endtask

   task automatic wait_drain(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < timeout_cycles && !ok; n++) begin
         @(negedge clk);
         ok = (pending == 0);
      end
      if (!ok) begin
         $display("output strobe never arrived, %0d item(s) still pending", pending);
      end
   endtask

   initial begin
      bit ok;
      int first;
      valid_i = 1'b0;
      k = '0;
      {a0, a1, a2, a3} = '0;
      {exp_y0, exp_y1, exp_y2, exp_y3} = '0;
      timed_out = 1'b0;
      n_filled = 0;
      lcg_state = 18393;
      build_twiddles();
      build_table();
      wait_reset(ok);
      timed_out = !ok;
      repeat (5) @(negedge clk);   // Idle with no strobe expected
      first = 0;
      for (int g = 0; g < n_groups && !timed_out; g++) begin
         drive_rows(first, grp_count[g]);
         wait_drain(ok);
         timed_out = !ok;
         first = first + grp_count[g];
      end
      repeat (4) @(negedge clk);
      $display("%0d of %0d items checked, %0d errors", checks, n_rows, errors);
      if (timed_out || errors != 0 || checks != n_rows) begin
         $display("TESTBENCH FAILED");
      end else begin
         $display("TESTBENCH PASSED");
      end
      $finish;
   end

endmodule
